/* verilog/iob_wb_consts.svh */
`ifndef IOB_WB_CONSTS_SVH
`define IOB_WB_CONSTS_SVH

// Bus widths.
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// Bytes enabled in a read select mask.
`define READ_BYTES 4

// Address map. Bit SLV_SEL_BIT picks SRAM (0) or GPIO (1).
`define SLV_SEL_BIT 12
`define SRAM_AW 8

// GPIO block.
`define GPIO_W 32
`define GPIO_OUT_OFS 0
`define GPIO_IN_OFS 4

`endif

/* verilog/iob_wb_pkg.sv */
`default_nettype none

`include "iob_wb_consts.svh"

package iob_wb_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`STRB_W-1:0] strb_t;
    typedef logic [`GPIO_W-1:0] gpio_t;

    // Master to slave.
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        strb_t sel;
        addr_t addr;
        data_t data;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic  ack;
        data_t data;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } bridge_state_t;

endpackage

`default_nettype wire

/* verilog/iob2wb_bridge.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module iob2wb_bridge import iob_wb_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,

    // IOb side.
    input  wire logic    iob_avalid_i,
    input  wire addr_t   iob_address_i,
    input  wire data_t   iob_wdata_i,
    input  wire strb_t   iob_wstrb_i,
    output logic         iob_rvalid_o,
    output data_t        iob_rdata_o,
    output logic         iob_ready_o,

    // Wishbone side.
    output wb_req_t      wb_req_o,
    input  wire wb_rsp_t wb_rsp_i
);

    localparam strb_t RB_MASK = strb_t'({`READ_BYTES{1'b1}});

    bridge_state_t state_q;
    bridge_state_t state_d;

    logic  start;
    logic  in_we;
    strb_t in_sel;

    addr_t addr_q;
    data_t wdata_q;
    strb_t sel_q;
    logic  we_q;

    logic  ready_q;
    logic  rvalid_q;
    data_t rdata_q;

    //------------------------------------------------------------------------
    // Request decode
    //------------------------------------------------------------------------
    assign start  = (state_q == ST_IDLE) && iob_avalid_i;
    assign in_we  = |iob_wstrb_i;                          // Any strobe bit is a write.
    assign in_sel = in_we ? iob_wstrb_i : strb_t'(RB_MASK << iob_address_i[1:0]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (iob_avalid_i) state_d = ST_WAIT;
            ST_WAIT: if (wb_rsp_i.ack) state_d = ST_RESP;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latched copies drive the bus after the first cycle.
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q  <= iob_address_i;
            wdata_q <= iob_wdata_i;
            sel_q   <= in_sel;
            we_q    <= in_we;
        end
    end

    //------------------------------------------------------------------------
    // Wishbone request
    //------------------------------------------------------------------------
    always_comb begin
        wb_req_o.cyc  = start || (state_q == ST_WAIT);
        wb_req_o.stb  = start || (state_q == ST_WAIT); // Low in ST_RESP.
        wb_req_o.we   = (state_q == ST_IDLE) ? in_we : we_q;
        wb_req_o.sel  = (state_q == ST_IDLE) ? in_sel : sel_q;
        wb_req_o.addr = (state_q == ST_IDLE) ? iob_address_i : addr_q;
        wb_req_o.data = (state_q == ST_IDLE) ? iob_wdata_i : wdata_q;
    end

    //------------------------------------------------------------------------
    // IOb response
    //------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            ready_q  <= (state_q == ST_WAIT) && wb_rsp_i.ack;
            rvalid_q <= (state_q == ST_WAIT) && wb_rsp_i.ack && !we_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_rsp_i.ack) rdata_q <= wb_rsp_i.data;
    end

    assign iob_ready_o  = ready_q;
    assign iob_rvalid_o = rvalid_q;
    assign iob_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* verilog/wb_slave_mux.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module wb_slave_mux import iob_wb_pkg::*; (
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o,
    output wb_req_t      sram_req_o,
    input  wire wb_rsp_t sram_rsp_i,
    output wb_req_t      gpio_req_o,
    input  wire wb_rsp_t gpio_rsp_i
);

    logic sel_gpio;

    assign sel_gpio = wb_req_i.addr[`SLV_SEL_BIT];

    // Both slaves see the payload. Only one sees the cycle.
    always_comb begin
        sram_req_o     = wb_req_i;
        sram_req_o.cyc = wb_req_i.cyc && !sel_gpio;
        sram_req_o.stb = wb_req_i.stb && !sel_gpio;

        gpio_req_o     = wb_req_i;
        gpio_req_o.cyc = wb_req_i.cyc && sel_gpio;
        gpio_req_o.stb = wb_req_i.stb && sel_gpio;
    end

    always_comb begin
        if (sel_gpio) wb_rsp_o = gpio_rsp_i;
        else wb_rsp_o = sram_rsp_i;
    end

endmodule

`default_nettype wire

/* verilog/wb_sram.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module wb_sram import iob_wb_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o
);

    data_t mem [0:(1 << `SRAM_AW)-1];

    logic [`SRAM_AW-1:0] word_idx;
    logic                go;
    logic                ack_q;
    data_t               rdata_q;

    assign word_idx = wb_req_i.addr[`SRAM_AW+1:2];
    assign go       = wb_req_i.cyc && wb_req_i.stb && !ack_q; // Once per strobe.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= go;
        end
    end

    // Byte lanes.
    always_ff @(posedge clk_i) begin
        if (go && wb_req_i.we) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (wb_req_i.sel[b]) mem[word_idx][8*b +: 8] <= wb_req_i.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (go && !wb_req_i.we) rdata_q <= mem[word_idx];
    end

    assign wb_rsp_o.ack  = ack_q;
    assign wb_rsp_o.data = rdata_q;

endmodule

`default_nettype wire

/* verilog/wb_gpio_regs.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module wb_gpio_regs import iob_wb_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o,
    input  wire gpio_t   gpio_i,
    output gpio_t        gpio_o
);

    logic [`SLV_SEL_BIT-1:0] reg_ofs;

    logic  go;
    logic  wait_q;
    logic  ack_q;
    logic  commit;
    data_t rd_word;
    data_t rdata_q;

    gpio_t out_q;
    gpio_t sync1_q;
    gpio_t sync2_q;

    assign reg_ofs = {wb_req_i.addr[`SLV_SEL_BIT-1:2], 2'b00};
    assign go      = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign commit  = go && wait_q;                       // Second strobe cycle.

    //------------------------------------------------------------------------
    // Wait state and acknowledge
    //------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            wait_q <= go && !wait_q;
            ack_q  <= commit;
        end
    end

    //------------------------------------------------------------------------
    // Registers
    //------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            if (commit && wb_req_i.we && reg_ofs == `GPIO_OUT_OFS) begin
                for (int b = 0; b < `STRB_W; b++) begin
                    if (wb_req_i.sel[b]) out_q[8*b +: 8] <= wb_req_i.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;                                    // Unmapped offsets.
        if (reg_ofs == `GPIO_OUT_OFS) rd_word = out_q;
        else if (reg_ofs == `GPIO_IN_OFS) rd_word = sync2_q;
    end

    always_ff @(posedge clk_i) begin
        if (commit && !wb_req_i.we) rdata_q <= rd_word;
    end

    assign wb_rsp_o.ack  = ack_q;
    assign wb_rsp_o.data = rdata_q;
    assign gpio_o        = out_q;

endmodule

`default_nettype wire

/* verilog/iob_wb_top.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module iob_wb_top import iob_wb_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  arst_n_i,

    input  wire logic  iob_avalid_i,
    input  wire addr_t iob_address_i,
    input  wire data_t iob_wdata_i,
    input  wire strb_t iob_wstrb_i,
    output logic       iob_rvalid_o,
    output data_t      iob_rdata_o,
    output logic       iob_ready_o,

    input  wire gpio_t gpio_i,
    output gpio_t      gpio_o
);

    wb_req_t bridge_req;
    wb_rsp_t bridge_rsp;
    wb_req_t sram_req;
    wb_rsp_t sram_rsp;
    wb_req_t gpio_req;
    wb_rsp_t gpio_rsp;

    iob2wb_bridge u_bridge (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .iob_avalid_i  (iob_avalid_i),
        .iob_address_i (iob_address_i),
        .iob_wdata_i   (iob_wdata_i),
        .iob_wstrb_i   (iob_wstrb_i),
        .iob_rvalid_o  (iob_rvalid_o),
        .iob_rdata_o   (iob_rdata_o),
        .iob_ready_o   (iob_ready_o),
        .wb_req_o      (bridge_req),
        .wb_rsp_i      (bridge_rsp)
    );

    wb_slave_mux u_mux (
        .wb_req_i   (bridge_req),
        .wb_rsp_o   (bridge_rsp),
        .sram_req_o (sram_req),
        .sram_rsp_i (sram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp)
    );

    wb_sram u_sram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_req_i (sram_req),
        .wb_rsp_o (sram_rsp)
    );

    wb_gpio_regs u_gpio (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_req_i (gpio_req),
        .wb_rsp_o (gpio_rsp),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o)
    );

endmodule

`default_nettype wire

/* bench/tb_iob_wb_top.sv */
`default_nettype none

`include "iob_wb_consts.svh"

module tb_iob_wb_top import iob_wb_pkg::*; ();

    localparam int    TIMEOUT_CYCLES = 20;
    localparam int    N_WORDS        = 40;
    localparam addr_t GPIO_BASE      = addr_t'(1) << `SLV_SEL_BIT;

    logic  clk;
    logic  arst_n;
    logic  iob_avalid;
    addr_t iob_address;
    data_t iob_wdata;
    strb_t iob_wstrb;
    logic  iob_rvalid;
    data_t iob_rdata;
    logic  iob_ready;
    gpio_t gpio_in;
    gpio_t gpio_out;

    data_t shadow_mem [0:(1 << `SRAM_AW)-1];
    gpio_t shadow_gpio;
    gpio_t gpio_in_model;

    logic  busy;                                        // Transfer in flight.
    logic  exp_read;
    data_t exp_rdata;

    logic [31:0] rng_state;
    addr_t       addr_list [0:N_WORDS-1];
    int          error_count;
    int          check_count;

    iob_wb_top u_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .iob_avalid_i  (iob_avalid),
        .iob_address_i (iob_address),
        .iob_wdata_i   (iob_wdata),
        .iob_wstrb_i   (iob_wstrb),
        .iob_rvalid_o  (iob_rvalid),
        .iob_rdata_o   (iob_rdata),
        .iob_ready_o   (iob_ready),
        .gpio_i        (gpio_in),
        .gpio_o        (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //--------------------------------------------------------------------------
    // Reference model
    //--------------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    function automatic data_t ref_read(addr_t addr);
        int ofs;
        ofs = int'({addr[`SLV_SEL_BIT-1:2], 2'b00});
        if (!addr[`SLV_SEL_BIT]) return shadow_mem[addr[`SRAM_AW+1:2]];
        if (ofs == `GPIO_OUT_OFS) return shadow_gpio;
        if (ofs == `GPIO_IN_OFS) return gpio_in_model;
        return '0;                                      // Unmapped offset.
    endfunction

    function automatic void apply_write(addr_t addr, data_t wdata, strb_t wstrb);
        if (wstrb == '0) return;
        if (!addr[`SLV_SEL_BIT]) begin
            shadow_mem[addr[`SRAM_AW+1:2]] = merge_bytes(ref_read(addr), wdata, wstrb);
        end else if (int'({addr[`SLV_SEL_BIT-1:2], 2'b00}) == `GPIO_OUT_OFS) begin
            shadow_gpio = merge_bytes(shadow_gpio, wdata, wstrb);
        end
    endfunction

    function automatic int latency_for(addr_t addr);
        return addr[`SLV_SEL_BIT] ? 3 : 2;              // GPIO has one wait state more.
    endfunction

    //--------------------------------------------------------------------------
    // Compare tasks
    //--------------------------------------------------------------------------
    task automatic check_data(string name, data_t expected, data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_gpio(string name, gpio_t expected, gpio_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_latency(string name, int expected, int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Response checker.
    always @(negedge clk) begin
        if (arst_n && iob_ready && !busy) begin
            error_count++;
            $display("Ready pulsed at %0t with no transfer in flight", $time);
        end else if (arst_n && iob_ready) begin
            check_flag("iob_rvalid_o", exp_read, iob_rvalid);
            if (exp_read) check_data("iob_rdata_o", exp_rdata, iob_rdata);
        end else if (arst_n && iob_rvalid) begin
            error_count++;
            $display("Read valid pulsed at %0t without ready", $time);
        end
    end

    // One IOb transfer. Cycle A is the first cycle sampled below.
    task automatic transfer(addr_t addr, data_t wdata, strb_t wstrb);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        iob_avalid  <= 1'b1;
        iob_address <= addr;
        iob_wdata   <= wdata;
        iob_wstrb   <= wstrb;
        exp_read  = (wstrb == '0);
        exp_rdata = ref_read(addr);
        busy      = 1'b1;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (iob_ready) done = 1'b1;
            else cycles++;
        end
        if (done) begin
            check_latency("iob_ready_o latency", latency_for(addr), cycles);
        end else begin
            error_count++;
            $display("Transfer to address %h got no ready within %0d cycles",
                     addr, TIMEOUT_CYCLES);
        end
        @(posedge clk);
        iob_avalid <= 1'b0;
        iob_wstrb  <= '0;
        busy = 1'b0;
        apply_write(addr, wdata, wstrb);
    endtask

    //--------------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        strb_t       strb;
        rng_state     = 32'h5369;
        error_count   = 0;
        check_count   = 0;
        busy          = 1'b0;
        exp_read      = 1'b0;
        exp_rdata     = '0;
        shadow_gpio   = '0;
        gpio_in_model = '0;
        arst_n      <= 1'b0;
        iob_avalid  <= 1'b0;
        iob_address <= '0;
        iob_wdata   <= '0;
        iob_wstrb   <= '0;
        gpio_in     <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("iob_ready_o", 1'b0, iob_ready);
        check_flag("iob_rvalid_o", 1'b0, iob_rvalid);
        check_gpio("gpio_o", '0, gpio_out);

        // Full-word SRAM writes, then read back with random byte offsets.
        for (int i = 0; i < N_WORDS; i++) begin
            rnd = next_rand();
            addr_list[i] = addr_t'({rnd[`SRAM_AW-1:0], 2'b00});
            transfer(addr_list[i], next_rand(), '1);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            rnd = next_rand();
            transfer(addr_list[i] | addr_t'(rnd[1:0]), rnd, '0);
        end

        // Partial-strobe SRAM writes.
        for (int i = 0; i < 30; i++) begin
            rnd  = next_rand();
            strb = rnd[`STRB_W-1:0];
            if (strb == '0) strb = strb_t'(2);
            transfer(addr_list[int'(rnd[15:8]) % N_WORDS], next_rand(), strb);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            transfer(addr_list[i], '0, '0);
        end

        // GPIO output register.
        for (int i = 0; i < 8; i++) begin
            rnd = next_rand();
            transfer(GPIO_BASE | `GPIO_OUT_OFS, rnd, strb_t'(rnd[31:28]) | strb_t'(1));
            @(negedge clk);
            check_gpio("gpio_o", shadow_gpio, gpio_out);
            transfer(GPIO_BASE | `GPIO_OUT_OFS, '0, '0);
        end

        // GPIO input through the synchroniser.
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            rnd = next_rand();
            gpio_in <= rnd;
            gpio_in_model = rnd;
            repeat (4) @(posedge clk);
            transfer(GPIO_BASE | `GPIO_IN_OFS, '0, '0);
        end
        transfer(GPIO_BASE | `GPIO_IN_OFS, next_rand(), '1);   // Ignored.
        transfer(GPIO_BASE | 32'h8, next_rand(), '1);
        @(negedge clk);
        check_gpio("gpio_o", shadow_gpio, gpio_out);
        transfer(GPIO_BASE | `GPIO_IN_OFS, '0, '0);
        transfer(GPIO_BASE | 32'h8, '0, '0);
        transfer(GPIO_BASE | 32'h3fc, '0, '0);

        // Back-to-back, alternating SRAM and GPIO.
        for (int i = 0; i < 16; i++) begin
            rnd = next_rand();
            if (i % 2 == 0) transfer(addr_list[i], rnd, strb_t'(rnd[3:0]) | strb_t'(4));
            else transfer(GPIO_BASE | `GPIO_OUT_OFS, rnd, strb_t'(rnd[7:4]) | strb_t'(1));
        end
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0) transfer(addr_list[i], '0, '0);
            else transfer(GPIO_BASE | `GPIO_OUT_OFS, '0, '0);
        end

        @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/iob_wb_pkg.sv
verilog/iob2wb_bridge.sv
verilog/wb_slave_mux.sv
verilog/wb_sram.sv
verilog/wb_gpio_regs.sv
verilog/iob_wb_top.sv
bench/tb_iob_wb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_iob_wb_top -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
